//--- Bender.yml
package:
  name: eth_mac_1g

sources:
  - hdl/eth_pkg.sv
  - hdl/mac_pkg.sv
  - hdl/eth_crc_8.sv
  - hdl/eth_mac_1g_rx.sv
  - hdl/eth_mac_1g_tx.sv
  - hdl/eth_mac_1g.sv
  - target: test
    files:
      - bench/tb_eth_mac_1g.sv

//--- bench/tb_eth_mac_1g.sv
module tb_eth_mac_1g;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MIN_PAYLOAD = mac_pkg::DEFAULT_MIN_FRAME_LENGTH - eth_pkg::FCS_LEN;
    localparam int IFG = mac_pkg::DEFAULT_IFG_LENGTH;
    localparam int TIMEOUT = 1000;

    // frame kinds
    localparam int KIND_GOOD = 0;
    localparam int KIND_FLIP = 1;
    localparam int KIND_RXER = 2;
    localparam int KIND_ABORT = 3;

    logic clk;
    logic reset_crc;
    logic [7:0] tx_axis_tdata;
    logic tx_axis_tvalid;
    logic tx_axis_tlast;
    logic tx_axis_tuser;
    logic tx_axis_tready;
    logic [7:0] rx_axis_tdata;
    logic rx_axis_tvalid;
    logic rx_axis_tlast;
    logic rx_axis_tuser;
    logic [7:0] gmii_rxd;
    logic gmii_rx_dv;
    logic gmii_rx_er;
    logic [7:0] gmii_txd;
    logic gmii_tx_en;
    logic gmii_tx_er;
    logic rx_error_bad_frame;
    logic rx_error_bad_fcs;

    logic [31:0] lfsr = 32'h6c85_6c8a;
    int error_count = 0;

    // expected frame, written by the stimulus
    logic [7:0] exp_pad [0:255];
    int exp_len;
    int frame_kind;
    int er_pos;
    int frames_sent = 0;
    int frames_checked = 0;

    // loopback fault injection
    int wire_idx;
    int flip_idx = -1;
    int er_idx = -1;
    logic [7:0] flip_mask = 8'h00;

    // monitor state
    logic [7:0] rx_q[$];
    logic [7:0] tx_q[$];
    logic rx_user;
    logic tx_er_seen = 1'b0;
    logic tx_en_prev = 1'b0;
    int rx_frames = 0;
    int bad_frame_cnt = 0;
    int bad_fcs_cnt = 0;
    int idle_run = 0;
    int tx_frames_seen = 0;

    eth_mac_1g dut0 (
        .clk               (clk),
        .reset_crc         (reset_crc),
        .tx_axis_tdata     (tx_axis_tdata),
        .tx_axis_tvalid    (tx_axis_tvalid),
        .tx_axis_tlast     (tx_axis_tlast),
        .tx_axis_tuser     (tx_axis_tuser),
        .tx_axis_tready    (tx_axis_tready),
        .rx_axis_tdata     (rx_axis_tdata),
        .rx_axis_tvalid    (rx_axis_tvalid),
        .rx_axis_tlast     (rx_axis_tlast),
        .rx_axis_tuser     (rx_axis_tuser),
        .gmii_rxd          (gmii_rxd),
        .gmii_rx_dv        (gmii_rx_dv),
        .gmii_rx_er        (gmii_rx_er),
        .gmii_txd          (gmii_txd),
        .gmii_tx_en        (gmii_tx_en),
        .gmii_tx_er        (gmii_tx_er),
        .rx_error_bad_frame(rx_error_bad_frame),
        .rx_error_bad_fcs  (rx_error_bad_fcs)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form, one step per bit
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic int take_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        take_bits = v;
    endfunction

    // reflected CRC-32 over the padded payload, returned inverted
    function automatic logic [31:0] ref_fcs(int n);
        logic [31:0] c;
        logic [7:0] b;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < n; i++) begin
            b = exp_pad[i];
            for (int j = 0; j < 8; j++) begin
                c = (c >> 1) ^ ((c[0] ^ b[j]) ? 32'hEDB8_8320 : 32'h0000_0000);
            end
        end
        ref_fcs = ~c;
    endfunction

    // expected octet at a position of the wire frame
    function automatic logic [7:0] wire_byte(int i, logic [31:0] fcs);
        if (i < 7) begin
            wire_byte = 8'h55;
        end else if (i == 7) begin
            wire_byte = 8'hD5;
        end else if (i < 8 + exp_len) begin
            wire_byte = exp_pad[i-8];
        end else begin
            wire_byte = fcs[8*(i-8-exp_len) +: 8];
        end
    endfunction

    task automatic close_run();
        $display("frames checked %0d, errors %0d", frames_checked, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // GMII loopback with bit flip and rx_er injection
    always @(posedge clk) begin
        gmii_rxd <= gmii_txd ^ ((gmii_tx_en && wire_idx == flip_idx) ? flip_mask : 8'h00);
        gmii_rx_dv <= gmii_tx_en;
        gmii_rx_er <= gmii_tx_er || (gmii_tx_en && wire_idx == er_idx);
        if (gmii_tx_en) begin
            wire_idx <= wire_idx + 1;
        end else begin
            wire_idx <= 0;
        end
    end

    // monitor, mid-cycle sampling
    always @(negedge clk) begin
        if (!reset_crc) begin
            if (rx_axis_tvalid) begin
                rx_q.push_back(rx_axis_tdata);
                if (rx_axis_tlast) begin
                    rx_user = rx_axis_tuser;
                    rx_frames++;
                end
            end
            if (rx_error_bad_frame) bad_frame_cnt++;
            if (rx_error_bad_fcs) bad_fcs_cnt++;
            if (gmii_tx_en) begin
                if (!tx_en_prev && tx_frames_seen > 0 && idle_run < IFG) begin
                    $display("error: gmii_tx_en was low for only %0d cycles between frames",
                        idle_run);
                    error_count++;
                end
                tx_q.push_back(gmii_txd);
                if (gmii_tx_er) tx_er_seen = 1'b1;
                idle_run = 0;
            end else begin
                if (tx_en_prev) tx_frames_seen++;
                idle_run++;
            end
            tx_en_prev = gmii_tx_en;
        end
    end

    task automatic compare_frame();
        logic [31:0] fcs;
        logic [7:0] exp;
        int n_tx;
        int n_rx;
        fcs = ref_fcs(exp_len);
        n_tx = (frame_kind == KIND_ABORT) ? 8 + exp_len + 1 : 8 + exp_len + eth_pkg::FCS_LEN;
        if (tx_q.size() != n_tx) begin
            $display("transmit frame has %0d octets, expected %0d", tx_q.size(), n_tx);
            error_count++;
        end else begin
            // the error octet of an aborted frame carries no data
            for (int i = 0; i < n_tx - (frame_kind == KIND_ABORT); i++) begin
                exp = wire_byte(i, fcs);
                if (tx_q[i] !== exp) begin
                    $display("error: gmii_txd octet %0d is %02h, expected %02h", i, tx_q[i], exp);
                    error_count++;
                end
            end
        end
        if (tx_er_seen !== (frame_kind == KIND_ABORT)) begin
            $display("error: gmii_tx_er seen %0h, expected %0h", tx_er_seen,
                frame_kind == KIND_ABORT);
            error_count++;
        end
        case (frame_kind)
            KIND_RXER: n_rx = er_pos + 1;
            // the error octet is taken as one of the four FCS octets
            KIND_ABORT: n_rx = exp_len + 1 - eth_pkg::FCS_LEN;
            default: n_rx = exp_len;
        endcase
        if (rx_q.size() != n_rx) begin
            $display("receive frame has %0d bytes, expected %0d", rx_q.size(), n_rx);
            error_count++;
        end else if (frame_kind != KIND_FLIP) begin
            for (int i = 0; i < n_rx; i++) begin
                if (rx_q[i] !== exp_pad[i]) begin
                    $display("error: rx_axis_tdata byte %0d is %02h, expected %02h",
                        i, rx_q[i], exp_pad[i]);
                    error_count++;
                end
            end
        end
        if (rx_user !== (frame_kind != KIND_GOOD)) begin
            $display("error: rx_axis_tuser on last byte is %0h, expected %0h", rx_user,
                frame_kind != KIND_GOOD);
            error_count++;
        end
        if (bad_frame_cnt != (frame_kind != KIND_GOOD)) begin
            $display("error: rx_error_bad_frame pulses %0h, expected %0h", bad_frame_cnt,
                frame_kind != KIND_GOOD);
            error_count++;
        end
        if (frame_kind != KIND_ABORT && bad_fcs_cnt != (frame_kind == KIND_FLIP)) begin
            $display("error: rx_error_bad_fcs pulses %0h, expected %0h", bad_fcs_cnt,
                frame_kind == KIND_FLIP);
            error_count++;
        end
    endtask

    // compare once both the receive and the transmit side closed the frame
    always @(posedge clk) begin
        if (rx_frames != frames_checked && tx_frames_seen != frames_checked) begin
            compare_frame();
            rx_q.delete();
            tx_q.delete();
            bad_frame_cnt = 0;
            bad_fcs_cnt = 0;
            tx_er_seen = 1'b0;
            frames_checked++;
        end
    end

    task automatic send_frame(int n, logic abort_last);
        int i;
        int wait_cycles;
        i = 0;
        wait_cycles = 0;
        @(posedge clk);
        tx_axis_tdata <= exp_pad[0];
        tx_axis_tvalid <= 1'b1;
        tx_axis_tlast <= (n == 1);
        tx_axis_tuser <= abort_last && (n == 1);
        while (i < n) begin
            @(posedge clk);
            if (tx_axis_tready) begin
                i++;
                wait_cycles = 0;
                if (i < n) begin
                    tx_axis_tdata <= exp_pad[i];
                    tx_axis_tlast <= (i == n - 1);
                    tx_axis_tuser <= abort_last && (i == n - 1);
                end else begin
                    tx_axis_tvalid <= 1'b0;
                    tx_axis_tlast <= 1'b0;
                    tx_axis_tuser <= 1'b0;
                end
            end else begin
                wait_cycles++;
                if (wait_cycles > TIMEOUT) begin
                    $display("timeout, tx_axis_tready stayed low at byte %0d", i);
                    error_count++;
                    close_run();
                end
            end
        end
    endtask

    task automatic run_frame(int kind, int n);
        int wait_cycles;
        frame_kind = kind;
        for (int i = 0; i < n; i++) begin
            exp_pad[i] = take_bits(8);
        end
        exp_len = (kind == KIND_ABORT || n >= MIN_PAYLOAD) ? n : MIN_PAYLOAD;
        for (int i = n; i < exp_len; i++) begin
            exp_pad[i] = 8'h00;
        end
        flip_idx <= -1;
        er_idx <= -1;
        if (kind == KIND_FLIP) begin
            // anywhere in payload, pad or FCS
            flip_idx <= 8 + take_bits(8) % (exp_len + eth_pkg::FCS_LEN);
            flip_mask <= 8'h01 << take_bits(3);
        end
        if (kind == KIND_RXER) begin
            er_pos = 4 + take_bits(5);
            er_idx <= 8 + er_pos;
        end
        frames_sent++;
        send_frame(n, kind == KIND_ABORT);
        wait_cycles = 0;
        while (frames_checked != frames_sent) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > TIMEOUT) begin
                $display("timeout, no received frame for frame %0d", frames_sent);
                error_count++;
                close_run();
            end
        end
    endtask

    initial begin
        reset_crc = 1'b1;
        tx_axis_tdata = 8'h00;
        tx_axis_tvalid = 1'b0;
        tx_axis_tlast = 1'b0;
        tx_axis_tuser = 1'b0;
        gmii_rxd = 8'h00;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        wire_idx = 0;
        repeat (4) @(posedge clk);
        reset_crc <= 1'b0;
        repeat (2) @(posedge clk);

        for (int k = 0; k < 4; k++) begin
            run_frame(KIND_GOOD, 60 + take_bits(8) % 141);
        end
        for (int k = 0; k < 3; k++) begin
            run_frame(KIND_GOOD, 1 + take_bits(6) % 59);
        end
        for (int k = 0; k < 2; k++) begin
            run_frame(KIND_FLIP, 60 + take_bits(8) % 141);
        end
        run_frame(KIND_RXER, 60 + take_bits(8) % 141);
        run_frame(KIND_ABORT, 20 + take_bits(5));
        // recovery after the error frames
        run_frame(KIND_GOOD, 60 + take_bits(8) % 141);

        repeat (IFG + 2) @(posedge clk);
        close_run();
    end

endmodule

//--- hdl/eth_crc_8.sv
module eth_crc_8 (
    input  eth_pkg::byte_t data_in,
    input  eth_pkg::crc_t  crc_state,
    output eth_pkg::crc_t  crc_next
);

    // reflected form of the IEEE 802.3 polynomial
    localparam eth_pkg::crc_t CRC_POLY = 32'hEDB8_8320;

    // eight bit steps, LSB of the octet first
    always_comb begin
        eth_pkg::crc_t crc;

        crc = crc_state;
        for (int i = 0; i < 8; i++) begin
            if (crc[0] ^ data_in[i]) begin
                crc = (crc >> 1) ^ CRC_POLY;
            end else begin
                crc = crc >> 1;
            end
        end
        crc_next = crc;
    end

endmodule

//--- hdl/eth_mac_1g.sv
module eth_mac_1g #(
    parameter int MIN_FRAME_LENGTH = mac_pkg::DEFAULT_MIN_FRAME_LENGTH,
    parameter int IFG_LENGTH = mac_pkg::DEFAULT_IFG_LENGTH
) (
    input  logic           clk,
    input  logic           reset_crc,

    // transmit stream
    input  eth_pkg::byte_t tx_axis_tdata,
    input  logic           tx_axis_tvalid,
    input  logic           tx_axis_tlast,
    input  logic           tx_axis_tuser,
    output logic           tx_axis_tready,

    // receive stream, no back-pressure
    output eth_pkg::byte_t rx_axis_tdata,
    output logic           rx_axis_tvalid,
    output logic           rx_axis_tlast,
    output logic           rx_axis_tuser,

    // GMII
    input  eth_pkg::byte_t gmii_rxd,
    input  logic           gmii_rx_dv,
    input  logic           gmii_rx_er,
    output eth_pkg::byte_t gmii_txd,
    output logic           gmii_tx_en,
    output logic           gmii_tx_er,

    // receive status pulses
    output logic           rx_error_bad_frame,
    output logic           rx_error_bad_fcs
);

    eth_mac_1g_rx rx_inst (
        .clk            (clk),
        .reset_crc      (reset_crc),
        .gmii_rxd       (gmii_rxd),
        .gmii_rx_dv     (gmii_rx_dv),
        .gmii_rx_er     (gmii_rx_er),
        .axis_tdata     (rx_axis_tdata),
        .axis_tvalid    (rx_axis_tvalid),
        .axis_tlast     (rx_axis_tlast),
        .axis_tuser     (rx_axis_tuser),
        .error_bad_frame(rx_error_bad_frame),
        .error_bad_fcs  (rx_error_bad_fcs)
    );

    eth_mac_1g_tx #(
        .MIN_FRAME_LENGTH(MIN_FRAME_LENGTH),
        .IFG_LENGTH      (IFG_LENGTH)
    ) tx_inst (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .axis_tdata (tx_axis_tdata),
        .axis_tvalid(tx_axis_tvalid),
        .axis_tlast (tx_axis_tlast),
        .axis_tuser (tx_axis_tuser),
        .axis_tready(tx_axis_tready),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_tx_er (gmii_tx_er)
    );

endmodule

//--- hdl/eth_mac_1g_rx.sv
module eth_mac_1g_rx (
    input  logic           clk,
    input  logic           reset_crc,
    input  eth_pkg::byte_t gmii_rxd,
    input  logic           gmii_rx_dv,
    input  logic           gmii_rx_er,
    output eth_pkg::byte_t axis_tdata,
    output logic           axis_tvalid,
    output logic           axis_tlast,
    output logic           axis_tuser,
    output logic           error_bad_frame,
    output logic           error_bad_fcs
);

    // depth of the input delay line, one more than the FCS
    localparam int DELAY = 5;

    mac_pkg::rx_state_t state, state_next;

    // index 0 is the newest octet
    eth_pkg::byte_t   rxd_d [DELAY];
    logic [DELAY-1:0] rx_dv_d;
    logic [DELAY-1:0] rx_er_d;

    eth_pkg::crc_t crc_state;
    eth_pkg::crc_t crc_next;
    logic          crc_clear;
    logic          crc_update;
    logic          fcs_match;

    logic tvalid_next;
    logic tlast_next;
    logic tuser_next;
    logic bad_frame_next;
    logic bad_fcs_next;

    eth_crc_8 crc_inst (
        .data_in  (rxd_d[DELAY-1]),
        .crc_state(crc_state),
        .crc_next (crc_next)
    );

    // the four newest octets are the FCS once rx_dv falls
    assign fcs_match = {rxd_d[0], rxd_d[1], rxd_d[2], rxd_d[3]} == ~crc_next;

    always_comb begin
        state_next = state;
        crc_clear = 1'b0;
        crc_update = 1'b0;
        tvalid_next = 1'b0;
        tlast_next = 1'b0;
        tuser_next = 1'b0;
        bad_frame_next = 1'b0;
        bad_fcs_next = 1'b0;

        case (state)
            mac_pkg::rx_idle: begin
                crc_clear = 1'b1;
                if (rx_dv_d[DELAY-1] && !rx_er_d[DELAY-1] &&
                        rxd_d[DELAY-1] == eth_pkg::SFD_BYTE) begin
                    state_next = mac_pkg::rx_payload;
                end
            end
            mac_pkg::rx_payload: begin
                crc_update = 1'b1;
                tvalid_next = 1'b1;
                if (rx_dv_d[DELAY-1] && rx_er_d[DELAY-1]) begin
                    // PHY error inside the payload cuts the frame here
                    tlast_next = 1'b1;
                    tuser_next = 1'b1;
                    bad_frame_next = 1'b1;
                    state_next = mac_pkg::rx_wait_last;
                end else if (!gmii_rx_dv) begin
                    tlast_next = 1'b1;
                    if (|rx_er_d[DELAY-2:0]) begin
                        // error flagged during the FCS octets
                        tuser_next = 1'b1;
                        bad_frame_next = 1'b1;
                    end else if (!fcs_match) begin
                        tuser_next = 1'b1;
                        bad_frame_next = 1'b1;
                        bad_fcs_next = 1'b1;
                    end
                    state_next = mac_pkg::rx_wait_last;
                end
            end
            mac_pkg::rx_wait_last: begin
                // let the frame tail drain from the delay line
                if (!rx_dv_d[DELAY-1]) begin
                    state_next = mac_pkg::rx_idle;
                end
            end
            default: begin
                state_next = mac_pkg::rx_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= mac_pkg::rx_idle;
            rx_dv_d <= '0;
            rx_er_d <= '0;
            axis_tvalid <= 1'b0;
            axis_tlast <= 1'b0;
            axis_tuser <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs <= 1'b0;
        end else begin
            state <= state_next;
            rx_dv_d <= {rx_dv_d[DELAY-2:0], gmii_rx_dv};
            rx_er_d <= {rx_er_d[DELAY-2:0], gmii_rx_er};
            axis_tvalid <= tvalid_next;
            axis_tlast <= tlast_next;
            axis_tuser <= tuser_next;
            error_bad_frame <= bad_frame_next;
            error_bad_fcs <= bad_fcs_next;
        end
    end

    // octet path, qualified by rx_dv and tvalid
    always_ff @(posedge clk) begin
        rxd_d[0] <= gmii_rxd;
        for (int i = 1; i < DELAY; i++) begin
            rxd_d[i] <= rxd_d[i-1];
        end
        axis_tdata <= rxd_d[DELAY-1];
        if (crc_clear) begin
            crc_state <= eth_pkg::CRC_INIT;
        end else if (crc_update) begin
            crc_state <= crc_next;
        end
    end

    // FCS failure is reported on the closing byte of the frame
    assert property (@(posedge clk) disable iff (reset_crc)
        error_bad_fcs |-> error_bad_frame && axis_tlast && axis_tuser)
        else $error("rx fcs error without bad frame on last byte");

    // a bad frame closes the burst
    assert property (@(posedge clk) disable iff (reset_crc)
        axis_tuser |-> axis_tlast ##1 !axis_tvalid)
        else $error("rx tuser outside the last byte of a frame");

endmodule

//--- hdl/eth_mac_1g_tx.sv
module eth_mac_1g_tx #(
    parameter int MIN_FRAME_LENGTH = mac_pkg::DEFAULT_MIN_FRAME_LENGTH,
    parameter int IFG_LENGTH = mac_pkg::DEFAULT_IFG_LENGTH
) (
    input  logic           clk,
    input  logic           reset_crc,
    input  eth_pkg::byte_t axis_tdata,
    input  logic           axis_tvalid,
    input  logic           axis_tlast,
    input  logic           axis_tuser,
    output logic           axis_tready,
    output eth_pkg::byte_t gmii_txd,
    output logic           gmii_tx_en,
    output logic           gmii_tx_er
);

    // payload plus pad, FCS excluded
    localparam int MIN_PAYLOAD = MIN_FRAME_LENGTH - eth_pkg::FCS_LEN;
    localparam int CNT_W = $clog2(MIN_FRAME_LENGTH + 1);
    localparam int GAP_W = $clog2(IFG_LENGTH + 1);

    mac_pkg::tx_state_t state, state_next;

    // preamble, payload or FCS position, saturating at MIN_PAYLOAD
    logic [CNT_W-1:0] byte_cnt, byte_cnt_next;
    logic [GAP_W-1:0] gap_cnt, gap_cnt_next;

    // frame closed with tuser, ends in an error octet
    logic abort, abort_next;

    eth_pkg::crc_t  crc_state;
    eth_pkg::crc_t  crc_next;
    eth_pkg::byte_t crc_data;
    logic           crc_clear;
    logic           crc_update;
    logic           crc_shift;

    eth_pkg::byte_t txd_next;
    logic           tx_en_next;
    logic           tx_er_next;
    logic           tready_next;

    eth_crc_8 crc_inst (
        .data_in  (crc_data),
        .crc_state(crc_state),
        .crc_next (crc_next)
    );

    // pad octets are zero
    assign crc_data = (state == mac_pkg::tx_pad) ? '0 : axis_tdata;

    always_comb begin
        state_next = state;
        byte_cnt_next = byte_cnt;
        gap_cnt_next = gap_cnt;
        abort_next = abort;
        crc_clear = 1'b0;
        crc_update = 1'b0;
        crc_shift = 1'b0;
        txd_next = '0;
        tx_en_next = 1'b0;
        tx_er_next = 1'b0;

        case (state)
            mac_pkg::tx_idle: begin
                crc_clear = 1'b1;
                abort_next = 1'b0;
                if (axis_tvalid) begin
                    // first preamble octet goes out right away
                    txd_next = eth_pkg::PREAMBLE_BYTE;
                    tx_en_next = 1'b1;
                    byte_cnt_next = CNT_W'(1);
                    state_next = mac_pkg::tx_preamble;
                end
            end
            mac_pkg::tx_preamble: begin
                tx_en_next = 1'b1;
                if (byte_cnt < eth_pkg::PREAMBLE_LEN) begin
                    txd_next = eth_pkg::PREAMBLE_BYTE;
                    byte_cnt_next = byte_cnt + 1'b1;
                end else begin
                    txd_next = eth_pkg::SFD_BYTE;
                    byte_cnt_next = '0;
                    state_next = mac_pkg::tx_payload;
                end
            end
            mac_pkg::tx_payload: begin
                tx_en_next = 1'b1;
                if (axis_tvalid) begin
                    txd_next = axis_tdata;
                    crc_update = 1'b1;
                    if (byte_cnt < MIN_PAYLOAD) begin
                        byte_cnt_next = byte_cnt + 1'b1;
                    end
                    if (axis_tlast) begin
                        if (axis_tuser) begin
                            abort_next = 1'b1;
                            state_next = mac_pkg::tx_fcs;
                        end else if (byte_cnt < MIN_PAYLOAD - 1) begin
                            state_next = mac_pkg::tx_pad;
                        end else begin
                            byte_cnt_next = '0;
                            state_next = mac_pkg::tx_fcs;
                        end
                    end
                end else begin
                    // underrun
                    tx_er_next = 1'b1;
                    gap_cnt_next = '0;
                    state_next = mac_pkg::tx_gap;
                end
            end
            mac_pkg::tx_pad: begin
                tx_en_next = 1'b1;
                crc_update = 1'b1;
                byte_cnt_next = byte_cnt + 1'b1;
                if (byte_cnt == CNT_W'(MIN_PAYLOAD - 1)) begin
                    byte_cnt_next = '0;
                    state_next = mac_pkg::tx_fcs;
                end
            end
            mac_pkg::tx_fcs: begin
                tx_en_next = 1'b1;
                gap_cnt_next = '0;
                if (abort) begin
                    tx_er_next = 1'b1;
                    state_next = mac_pkg::tx_gap;
                end else begin
                    txd_next = ~crc_state[7:0];
                    crc_shift = 1'b1;
                    byte_cnt_next = byte_cnt + 1'b1;
                    if (byte_cnt == CNT_W'(eth_pkg::FCS_LEN - 1)) begin
                        state_next = mac_pkg::tx_gap;
                    end
                end
            end
            mac_pkg::tx_gap: begin
                gap_cnt_next = gap_cnt + 1'b1;
                if (gap_cnt == GAP_W'(IFG_LENGTH - 1)) begin
                    state_next = mac_pkg::tx_idle;
                end
            end
            default: begin
                state_next = mac_pkg::tx_idle;
            end
        endcase
    end

    // tready follows the registered state
    assign tready_next = (state_next == mac_pkg::tx_payload);

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= mac_pkg::tx_idle;
            byte_cnt <= '0;
            gap_cnt <= '0;
            abort <= 1'b0;
            axis_tready <= 1'b0;
            gmii_tx_en <= 1'b0;
            gmii_tx_er <= 1'b0;
        end else begin
            state <= state_next;
            byte_cnt <= byte_cnt_next;
            gap_cnt <= gap_cnt_next;
            abort <= abort_next;
            axis_tready <= tready_next;
            gmii_tx_en <= tx_en_next;
            gmii_tx_er <= tx_er_next;
        end
    end

    always_ff @(posedge clk) begin
        gmii_txd <= txd_next;
        if (crc_clear) begin
            crc_state <= eth_pkg::CRC_INIT;
        end else if (crc_update) begin
            crc_state <= crc_next;
        end else if (crc_shift) begin
            // next FCS octet moves to the bottom
            crc_state <= {8'h00, crc_state[31:8]};
        end
    end

    assert property (@(posedge clk) disable iff (reset_crc)
        axis_tready |-> state == mac_pkg::tx_payload)
        else $error("tx tready high outside payload");

    // error octet is the final octet of its frame
    assert property (@(posedge clk) disable iff (reset_crc)
        gmii_tx_er |-> gmii_tx_en ##1 !gmii_tx_en)
        else $error("tx_er not followed by end of frame");

endmodule

//--- hdl/eth_pkg.sv
package eth_pkg;

    // one octet on GMII or on the byte stream
    typedef logic [7:0] byte_t;

    // running CRC-32 register, reflected form
    typedef logic [31:0] crc_t;

    // CRC register start value
    localparam crc_t CRC_INIT = 32'hFFFF_FFFF;

    // preamble and start-of-frame delimiter octets
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE = 8'hD5;

    // preamble octets sent ahead of the SFD
    localparam int PREAMBLE_LEN = 7;

    // FCS octets at the tail of every frame, sent LSB byte first
    localparam int FCS_LEN = 4;

endpackage

//--- hdl/mac_pkg.sv
package mac_pkg;

    // receive framer states
    typedef enum logic [1:0] {
        rx_idle,
        rx_payload,
        rx_wait_last
    } rx_state_t;

    // transmit framer states
    typedef enum logic [2:0] {
        tx_idle,
        tx_preamble,
        tx_payload,
        tx_pad,
        tx_fcs,
        tx_gap
    } tx_state_t;

    // minimum frame on the wire, FCS included, preamble excluded
    localparam int DEFAULT_MIN_FRAME_LENGTH = 64;

    // idle octets between two frames
    localparam int DEFAULT_IFG_LENGTH = 12;

endpackage

//--- list.f
hdl/eth_pkg.sv
hdl/mac_pkg.sv
hdl/eth_crc_8.sv
hdl/eth_mac_1g_rx.sv
hdl/eth_mac_1g_tx.sv
hdl/eth_mac_1g.sv
bench/tb_eth_mac_1g.sv
